/* hdl/icache_pkg.sv */
package icache_pkg;

    // address and data
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // line geometry, 64 byte lines
    localparam int words_per_line = 16;
    localparam int word_sel_w = 4;          // addr 5:2
    localparam int line_off_w = 6;

    // set and way geometry
    localparam int num_sets = 4;
    localparam int set_sel_w = 2;           // addr 7:6
    localparam int num_ways = 4;
    localparam int way_sel_w = 2;

    localparam int tag_w = 24;              // addr 31:8

    // m_arlen values, beats minus one
    localparam logic [3:0] burst_line = 4'd15;
    localparam logic [3:0] burst_single = 4'd0;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_uncached,
        st_respond
    } icache_state_e;

endpackage

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cache_ena,

    input  logic                         s_arvalid,
    input  logic [icache_pkg::addr_w-1:0] s_araddr,
    output logic                         s_rvalid,
    output logic [icache_pkg::data_w-1:0] s_rdata,

    output logic                         m_arvalid,
    output logic [icache_pkg::addr_w-1:0] m_araddr,
    output logic [3:0]                   m_arlen,
    input  logic                         m_arready,
    input  logic                         m_rvalid,
    input  logic                         m_rlast,
    input  logic [icache_pkg::data_w-1:0] m_rdata,

    output logic [icache_pkg::addr_w-1:0] req_addr,
    input  logic                         hit,
    input  logic [icache_pkg::data_w-1:0] rd_data,
    output logic                         fill_we,
    output logic                         fill_done
);
    import icache_pkg::*;

    icache_state_e state_q;

    logic              accept;
    logic              lookup_hit;
    logic              lookup_miss;
    logic              unc_beat;
    logic [addr_w-1:0] line_addr;

    assign accept      = (state_q == st_idle) && s_arvalid;
    assign lookup_hit  = (state_q == st_lookup) && hit;
    assign lookup_miss = (state_q == st_lookup) && !hit;
    assign unc_beat    = (state_q == st_uncached) && m_rvalid;
    assign line_addr   = {req_addr[addr_w-1:line_off_w], {line_off_w{1'b0}}};

    // refill beats go straight to the line store
    assign fill_we   = (state_q == st_refill) && m_rvalid;
    assign fill_done = fill_we && m_rlast;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            s_rvalid  <= 1'b0;
            m_arvalid <= 1'b0;
        end else begin
            if (m_arvalid && m_arready) begin
                m_arvalid <= 1'b0;          // address taken
            end
            case (state_q)
                st_idle: begin
                    if (s_arvalid) begin
                        if (cache_ena) begin
                            state_q <= st_lookup;
                        end else begin
                            state_q   <= st_uncached;
                            m_arvalid <= 1'b1;
                        end
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        s_rvalid <= 1'b1;
                        state_q  <= st_respond;
                    end else begin
                        m_arvalid <= 1'b1;  // line refill
                        state_q   <= st_refill;
                    end
                end
                st_refill: begin
                    if (fill_done) begin
                        state_q <= st_lookup;   // retry, hits now
                    end
                end
                st_uncached: begin
                    if (m_rvalid) begin
                        s_rvalid <= 1'b1;
                        state_q  <= st_respond;
                    end
                end
                st_respond: begin
                    s_rvalid <= 1'b0;
                    state_q  <= st_idle;
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // request, memory address and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= s_araddr;
        end
        if (accept && !cache_ena) begin
            m_araddr <= s_araddr;       // exact word, no fill
            m_arlen  <= burst_single;
        end else if (lookup_miss) begin
            m_araddr <= line_addr;
            m_arlen  <= burst_line;
        end
        if (lookup_hit) begin
            s_rdata <= rd_data;
        end else if (unc_beat) begin
            s_rdata <= m_rdata;
        end
    end

    // address phase held until memory takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        (m_arvalid && !m_arready) |=>
            (m_arvalid && $stable(m_araddr) && $stable(m_arlen)))
        else $error("m_arvalid dropped or address changed before m_arready");

    assert property (@(posedge clk) disable iff (!rst_n)
        s_rvalid |=> !s_rvalid)
        else $error("s_rvalid high for two cycles");

endmodule

/* hdl/icache_tag_store.sv */
`timescale 1ns/1ps

module icache_tag_store (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [icache_pkg::addr_w-1:0]    req_addr,
    output logic                            hit,
    output logic [icache_pkg::way_sel_w-1:0] hit_way,
    output logic [icache_pkg::way_sel_w-1:0] fill_way,
    input  logic                            fill_done
);
    import icache_pkg::*;

    logic [tag_w-1:0]     tag_q [num_sets][num_ways];
    logic [num_ways-1:0]  valid_q [num_sets];
    logic [way_sel_w-1:0] fifo_ptr [num_sets];

    logic [set_sel_w-1:0] set_idx;
    logic [tag_w-1:0]     req_tag;
    logic [num_ways-1:0]  way_hit;

    assign set_idx = req_addr[line_off_w +: set_sel_w];
    assign req_tag = req_addr[addr_w-1 -: tag_w];

    // oldest way of the set gets the next refill
    assign fill_way = fifo_ptr[set_idx];

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == req_tag);
        end
    end

    assign hit = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_hit[w]) begin
                hit_way = way_sel_w'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[set_idx][fill_way] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s]  <= '0;
                fifo_ptr[s] <= '0;
            end
        end else if (fill_done) begin
            valid_q[set_idx][fill_way] <= 1'b1;
            fifo_ptr[set_idx]          <= fifo_ptr[set_idx] + 1'b1;   // wraps over 4 ways
        end
    end

    // a line is only refilled after a miss, so no tag lives twice in a set
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit))
        else $error("more than one way hit in set %0d", set_idx);

endmodule

/* hdl/icache_line_store.sv */
`timescale 1ns/1ps

module icache_line_store (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [icache_pkg::addr_w-1:0]    req_addr,
    input  logic [icache_pkg::way_sel_w-1:0] hit_way,
    output logic [icache_pkg::data_w-1:0]    rd_data,
    input  logic                            fill_we,
    input  logic [icache_pkg::way_sel_w-1:0] fill_way,
    input  logic [icache_pkg::data_w-1:0]    m_rdata
);
    import icache_pkg::*;

    logic [data_w-1:0] data_q [num_sets][num_ways][words_per_line];

    logic [set_sel_w-1:0]  set_idx;
    logic [word_sel_w-1:0] word_idx;
    logic [word_sel_w-1:0] word_cnt;

    assign set_idx  = req_addr[line_off_w +: set_sel_w];
    assign word_idx = req_addr[line_off_w-1 -: word_sel_w];

    // beats arrive in order from word 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (fill_we) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_q[set_idx][fill_way][word_cnt] <= m_rdata;
        end
    end

    assign rd_data = data_q[set_idx][hit_way][word_idx];

    // controller leaves refill right after the last beat
    assert property (@(posedge clk) disable iff (!rst_n)
        (fill_we && (&word_cnt)) |=> (!fill_we && (word_cnt == '0)))
        else $error("word counter not back at zero after a full line");

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cache_ena,

    input  logic                         s_arvalid,
    input  logic [icache_pkg::addr_w-1:0] s_araddr,
    output logic                         s_rvalid,
    output logic [icache_pkg::data_w-1:0] s_rdata,

    output logic                         m_arvalid,
    output logic [icache_pkg::addr_w-1:0] m_araddr,
    output logic [3:0]                   m_arlen,
    input  logic                         m_arready,
    input  logic                         m_rvalid,
    input  logic                         m_rlast,
    input  logic [icache_pkg::data_w-1:0] m_rdata,
    output logic                         m_rready
);
    import icache_pkg::*;

    logic [addr_w-1:0]    req_addr;
    logic                 hit;
    logic [way_sel_w-1:0] hit_way;
    logic [way_sel_w-1:0] fill_way;
    logic [data_w-1:0]    rd_data;
    logic                 fill_we;
    logic                 fill_done;

    assign m_rready = 1'b1;             // beats never stalled

    icache_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cache_ena (cache_ena),
        .s_arvalid (s_arvalid),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rdata   (s_rdata),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_rlast   (m_rlast),
        .m_rdata   (m_rdata),
        .req_addr  (req_addr),
        .hit       (hit),
        .rd_data   (rd_data),
        .fill_we   (fill_we),
        .fill_done (fill_done)
    );

    icache_tag_store u_tags (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_addr  (req_addr),
        .hit       (hit),
        .hit_way   (hit_way),
        .fill_way  (fill_way),
        .fill_done (fill_done)
    );

    icache_line_store u_lines (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_addr (req_addr),
        .hit_way  (hit_way),
        .rd_data  (rd_data),
        .fill_we  (fill_we),
        .fill_way (fill_way),
        .m_rdata  (m_rdata)
    );

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter logic [31:0] seed = 32'h0ba0_0047
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        m_arvalid,
    input  logic [31:0] m_araddr,
    input  logic [3:0]  m_arlen,
    output logic        m_arready,
    output logic        m_rvalid,
    output logic        m_rlast,
    output logic [31:0] m_rdata
);

    logic [31:0] rng;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory contents follow the byte address
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        logic [31:0] addr;
        logic [3:0]  len;
        int          wait_cycles;
        rng       = seed;
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_rlast   = 1'b0;
        m_rdata   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && m_arvalid) begin
                addr        = m_araddr;
                len         = m_arlen;
                rng         = xorshift32(rng);
                wait_cycles = int'(rng[1:0]);   // 0 to 3 cycles
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                m_arready = 1'b1;
                @(posedge clk);
                #1;
                m_arready = 1'b0;
                for (int beat = 0; beat <= int'(len); beat++) begin
                    m_rvalid = 1'b1;
                    m_rdata  = word_at(addr + 32'(beat * 4));
                    m_rlast  = (beat == int'(len));
                    @(posedge clk);
                    #1;
                end
                m_rvalid = 1'b0;
                m_rlast  = 1'b0;
            end
        end
    end

endmodule

/* tb/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam logic [31:0] rng_seed = 32'h0ba0_0047;
    localparam int timeout_cycles = 200;

    logic        clk;
    logic        rst_n;
    logic        cache_ena;
    logic        s_arvalid;
    logic [31:0] s_araddr;
    logic        s_rvalid;
    logic [31:0] s_rdata;
    logic        m_arvalid;
    logic [31:0] m_araddr;
    logic [3:0]  m_arlen;
    logic        m_arready;
    logic        m_rvalid;
    logic        m_rlast;
    logic [31:0] m_rdata;
    logic        m_rready;

    logic        req_seen;
    logic        expect_hit;
    logic        expect_miss;
    logic [31:0] rng;
    int          fail_count;
    int          test_count;
    int          fails_before;

    always #4 clk = ~clk;

    icache_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cache_ena (cache_ena),
        .s_arvalid (s_arvalid),
        .s_araddr  (s_araddr),
        .s_rvalid  (s_rvalid),
        .s_rdata   (s_rdata),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_rlast   (m_rlast),
        .m_rdata   (m_rdata),
        .m_rready  (m_rready)
    );

    tb_mem_model #(.seed(rng_seed)) mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_rlast   (m_rlast),
        .m_rdata   (m_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    // outputs checked on the falling edge
    assert property (@(negedge clk) disable iff (!rst_n)
        !req_seen |-> (!s_rvalid && !m_arvalid))
        else begin
            $display("error %0t: s_rvalid or m_arvalid high before any request", $time);
            fail_count++;
        end

    // data beats are never stalled
    assert property (@(negedge clk) disable iff (!rst_n)
        m_rready)
        else begin
            $display("error %0t: m_rready low", $time);
            fail_count++;
        end

    assert property (@(negedge clk) disable iff (!rst_n)
        s_rvalid |-> (s_rdata == expected_word(s_araddr)))
        else begin
            $display("error %0t: s_rdata %h for address %h, expected %h",
                     $time, s_rdata, s_araddr, expected_word(s_araddr));
            fail_count++;
        end

    assert property (@(negedge clk) disable iff (!rst_n)
        m_arvalid |-> (cache_ena ?
            (m_araddr == {s_araddr[31:6], 6'b0} && m_arlen == 4'd15) :
            (m_araddr == s_araddr && m_arlen == 4'd0)))
        else begin
            $display("error %0t: m_araddr %h m_arlen %0d for request %h cache_ena %b",
                     $time, m_araddr, m_arlen, s_araddr, cache_ena);
            fail_count++;
        end

    // hit answers two edges after acceptance without a memory access
    assert property (@(negedge clk) disable iff (!rst_n)
        ($rose(s_arvalid) && expect_hit) |->
            (!m_arvalid && !s_rvalid) ##1 (!m_arvalid && !s_rvalid)
            ##1 (s_rvalid && !m_arvalid))
        else begin
            $display("error %0t: read of %h did not hit in 2 cycles", $time, s_araddr);
            fail_count++;
        end

    assert property (@(negedge clk) disable iff (!rst_n)
        ($rose(s_arvalid) && expect_miss) |-> ##2 m_arvalid)
        else begin
            $display("error %0t: read of %h did not start a refill", $time, s_araddr);
            fail_count++;
        end

    assert property (@(negedge clk) disable iff (!rst_n)
        ($rose(s_arvalid) && !cache_ena) |-> ##1 m_arvalid)
        else begin
            $display("error %0t: uncached read of %h did not fetch", $time, s_araddr);
            fail_count++;
        end

    task automatic read_word(input logic [31:0] addr, input logic ena,
                             input logic hit_exp, input logic miss_exp);
        int cycles;
        s_araddr    = addr;
        cache_ena   = ena;
        expect_hit  = hit_exp;
        expect_miss = miss_exp;
        s_arvalid   = 1'b1;
        req_seen    = 1'b1;
        cycles      = 0;
        while (!s_rvalid && cycles < timeout_cycles) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!s_rvalid) begin
            $display("timeout: no response to the read of %h within %0d cycles",
                     addr, timeout_cycles);
            fail_count++;
        end
        s_arvalid   = 1'b0;
        expect_hit  = 1'b0;
        expect_miss = 1'b0;
        @(posedge clk);             // controller back to idle
        #1;
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (fail_count == fails_before) begin
            $display("test %0d %s: passed", test_count, name);
        end else begin
            $display("test %0d %s: %0d failures", test_count, name, fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    initial begin
        int i;
        clk          = 1'b0;
        rst_n        = 1'b0;
        cache_ena    = 1'b1;
        s_arvalid    = 1'b0;
        s_araddr     = '0;
        req_seen     = 1'b0;
        expect_hit   = 1'b0;
        expect_miss  = 1'b0;
        rng          = rng_seed;
        fail_count   = 0;
        test_count   = 0;
        fails_before = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (6) @(posedge clk);
        #1;
        report_test("reset");

        read_word(32'h0000_1024, 1'b1, 1'b0, 1'b1);
        report_test("cold miss");

        read_word(32'h0000_1008, 1'b1, 1'b1, 1'b0);     // same line as above
        read_word(32'h0000_103c, 1'b1, 1'b1, 1'b0);
        report_test("hit");

        read_word(32'h0000_3084, 1'b0, 1'b0, 1'b0);
        read_word(32'h0000_3084, 1'b1, 1'b0, 1'b1);     // no fill from the uncached read
        report_test("uncached read");

        // tags A to E in set 1
        for (i = 0; i < 5; i++) begin
            read_word(32'h0002_0040 + 32'(i * 256), 1'b1, 1'b0, 1'b1);
        end
        for (i = 1; i < 5; i++) begin
            read_word(32'h0002_0048 + 32'(i * 256), 1'b1, 1'b1, 1'b0);
        end
        read_word(32'h0002_0040, 1'b1, 1'b0, 1'b1);     // A was evicted by E
        report_test("fifo replacement");

        for (i = 0; i < 200; i++) begin
            rng = xorshift32(rng);
            read_word(rng & 32'h0000_0ffc, rng[21:20] != 2'b00, 1'b0, 1'b0);
        end
        report_test("random reads");

        $display("%0d tests run, %0d checks failed", test_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/icache_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_tag_store.sv
hdl/icache_line_store.sv
hdl/icache_top.sv
tb/tb_mem_model.sv
tb/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# builds the icache testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    -f src.f \
    --top-module tb_icache

./obj_dir/Vtb_icache | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "icache simulation reported a failure"
    exit 1
fi

if ! grep -q "Everything OK" sim.log; then
    echo "icache simulation ended without a result"
    exit 1
fi

echo "icache simulation passed"
